/* rtl/rvv_cfg_pkg.sv */
package rvv_cfg_pkg;

	// architectural sizes
	localparam int VLEN      = 128;
	localparam int VLENB     = VLEN / 8;
	localparam int NUM_VREGS = 32;
	localparam int MAX_LMUL  = 8;

	typedef logic [VLEN-1:0] vreg_t;  // one vector register
	typedef logic [4:0]      vaddr_t; // register number
	typedef logic [31:0]     word_t;  // scalar word

	// counts up to VLENB * MAX_LMUL inclusive
	typedef logic [$clog2(VLENB*MAX_LMUL+1):0] vl_t;

	// vsew encodings that are accepted, anything else makes vill
	typedef enum logic [2:0] {
		E8  = 3'b000,
		E16 = 3'b001,
		E32 = 3'b010
	} sew_e;

	// vtype CSR, vill is bit 31 and the rest sits in bits 7..0
	typedef struct packed {
		logic       vill;
		logic       vma;
		logic       vta;
		logic [2:0] sew;
		logic [2:0] lmul;
	} vtype_t;

endpackage

/* rtl/rvv_pcpi_pkg.sv */
package rvv_pcpi_pkg;

	// major opcodes
	localparam logic [6:0] OPC_OP_V     = 7'b1010111;
	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

	localparam logic [2:0] F3_OPIVV = 3'b000;
	localparam logic [2:0] F3_OPMVV = 3'b010;
	localparam logic [2:0] F3_OPIVI = 3'b011;
	localparam logic [2:0] F3_OPIVX = 3'b100;
	localparam logic [2:0] F3_CFG   = 3'b111;

	localparam logic [5:0] F6_VMV       = 6'b010111;
	localparam logic [5:0] F6_VWXUNARY0 = 6'b010000;

	// width field of vector load/store
	localparam logic [2:0] MEM_W8  = 3'b000;
	localparam logic [2:0] MEM_W16 = 3'b101;
	localparam logic [2:0] MEM_W32 = 3'b110;

	typedef enum logic [2:0] {
		CLS_NONE = 3'd0,
		CLS_CFG,
		CLS_LOAD,
		CLS_STORE,
		CLS_MOVE,
		CLS_MVXS
	} insn_class_e;

	typedef enum logic [1:0] {SRC_VEC, SRC_SCALAR, SRC_IMM} mv_src_e;

	typedef enum logic [1:0] {CFG_VLI, CFG_VILI, CFG_VL} cfg_kind_e;

	typedef struct packed {
		insn_class_e         cls;
		mv_src_e             src;
		cfg_kind_e           cfg;
		rvv_cfg_pkg::sew_e   mem_sew;   // element width of a load/store
		rvv_cfg_pkg::vaddr_t vd;
		rvv_cfg_pkg::vaddr_t vs1;
		rvv_cfg_pkg::vaddr_t vs2;
		logic                rs1_nonzero;
		logic                rd_nonzero;
		logic [4:0]          imm;
		rvv_cfg_pkg::vtype_t vtype_imm; // zimm of vsetvli/vsetivli
	} dec_t;

	typedef struct packed {
		logic                valid;
		rvv_cfg_pkg::word_t  insn;
		rvv_cfg_pkg::word_t  rs1;
		rvv_cfg_pkg::word_t  rs2;
	} pcpi_req_t;

	typedef struct packed {
		logic                wr;
		rvv_cfg_pkg::word_t  rd;
		logic                waiting;
		logic                ready;
	} pcpi_rsp_t;

	typedef struct packed {
		logic                valid;
		logic                store;
		rvv_cfg_pkg::word_t  addr;
		rvv_cfg_pkg::word_t  wdata;
		logic [3:0]          strb;
	} mem_req_t;

	typedef struct packed {
		logic                en;
		rvv_cfg_pkg::vaddr_t addr;
		rvv_cfg_pkg::vreg_t  data;
	} vrf_wr_t;

	typedef struct packed {
		rvv_cfg_pkg::vaddr_t addr;
	} vrf_rd_t;

endpackage

/* rtl/rvv_decoder.sv */
`timescale 1ns/100ps

module rvv_decoder (
	input  rvv_cfg_pkg::word_t  insn_i,
	output rvv_pcpi_pkg::dec_t  dec_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [5:0] funct6;
	logic       vm;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];
	assign funct6 = insn_i[31:26];
	assign vm     = insn_i[25];

	always_comb begin
		dec_o             = '0;
		dec_o.vd          = insn_i[11:7];
		dec_o.vs1         = insn_i[19:15];
		dec_o.vs2         = insn_i[24:20];
		dec_o.imm         = insn_i[19:15];
		dec_o.rs1_nonzero = |insn_i[19:15];
		dec_o.rd_nonzero  = |insn_i[11:7];
		// reserved zimm bits are 30:28 for vsetvli, 29:28 for vsetivli
		dec_o.vtype_imm   = {insn_i[31] ? |insn_i[29:28] : |insn_i[30:28], insn_i[27:20]};

		if (opcode == rvv_pcpi_pkg::OPC_OP_V && funct3 == rvv_pcpi_pkg::F3_CFG) begin
			if (!insn_i[31]) begin
				dec_o.cls = rvv_pcpi_pkg::CLS_CFG;
				dec_o.cfg = rvv_pcpi_pkg::CFG_VLI;
			end else if (insn_i[31:30] == 2'b11) begin
				dec_o.cls = rvv_pcpi_pkg::CLS_CFG;
				dec_o.cfg = rvv_pcpi_pkg::CFG_VILI;
			end else if (insn_i[31:25] == 7'b1000000) begin
				dec_o.cls = rvv_pcpi_pkg::CLS_CFG;
				dec_o.cfg = rvv_pcpi_pkg::CFG_VL;
			end
		end else if (opcode == rvv_pcpi_pkg::OPC_OP_V && vm) begin
			if (funct6 == rvv_pcpi_pkg::F6_VMV && insn_i[24:20] == 5'd0) begin
				dec_o.cls = rvv_pcpi_pkg::CLS_MOVE;
				case (funct3)
					rvv_pcpi_pkg::F3_OPIVV: dec_o.src = rvv_pcpi_pkg::SRC_VEC;
					rvv_pcpi_pkg::F3_OPIVX: dec_o.src = rvv_pcpi_pkg::SRC_SCALAR;
					rvv_pcpi_pkg::F3_OPIVI: dec_o.src = rvv_pcpi_pkg::SRC_IMM;
					default:                dec_o.cls = rvv_pcpi_pkg::CLS_NONE;
				endcase
			end else if (funct6 == rvv_pcpi_pkg::F6_VWXUNARY0
					&& funct3 == rvv_pcpi_pkg::F3_OPMVV && insn_i[19:15] == 5'd0) begin
				dec_o.cls = rvv_pcpi_pkg::CLS_MVXS;
			end
		end else if ((opcode == rvv_pcpi_pkg::OPC_LOAD_FP || opcode == rvv_pcpi_pkg::OPC_STORE_FP)
				&& funct6 == 6'd0 && vm && insn_i[24:20] == 5'd0) begin
			// unit stride only: nf, mew, mop and lumop all zero
			dec_o.cls = (opcode == rvv_pcpi_pkg::OPC_STORE_FP) ? rvv_pcpi_pkg::CLS_STORE
			                                                  : rvv_pcpi_pkg::CLS_LOAD;
			case (funct3)
				rvv_pcpi_pkg::MEM_W8:  dec_o.mem_sew = rvv_cfg_pkg::E8;
				rvv_pcpi_pkg::MEM_W16: dec_o.mem_sew = rvv_cfg_pkg::E16;
				rvv_pcpi_pkg::MEM_W32: dec_o.mem_sew = rvv_cfg_pkg::E32;
				default:               dec_o.cls = rvv_pcpi_pkg::CLS_NONE; // e64 or fp width
			endcase
		end
	end

endmodule

/* rtl/rvv_csr.sv */
`timescale 1ns/100ps

module rvv_csr (
	input  logic                clk,
	input  logic                resetn,
	input  logic                start_i,
	input  rvv_pcpi_pkg::dec_t  dec_i,
	input  rvv_cfg_pkg::word_t  rs1_i,
	input  rvv_cfg_pkg::word_t  rs2_i,
	output rvv_cfg_pkg::vtype_t vtype_o,
	output rvv_cfg_pkg::vl_t    vl_o,
	output logic                done_o
);
	rvv_cfg_pkg::vtype_t vt_new;
	rvv_cfg_pkg::vl_t    vlmax;
	rvv_cfg_pkg::vl_t    vl_new;
	rvv_cfg_pkg::word_t  avl;
	logic                legal;

	always_comb begin
		if (dec_i.cfg == rvv_pcpi_pkg::CFG_VL)
			vt_new = {rs2_i[31] | (|rs2_i[30:8]), rs2_i[7:0]}; // any reserved bit -> vill
		else
			vt_new = dec_i.vtype_imm;

		// fractional and reserved lmul have bit 2 set
		legal = !vt_new.vill && !vt_new.lmul[2] && vt_new.sew inside
			{rvv_cfg_pkg::E8, rvv_cfg_pkg::E16, rvv_cfg_pkg::E32};
		vlmax = rvv_cfg_pkg::vl_t'(rvv_cfg_pkg::VLENB >> vt_new.sew) << vt_new.lmul[1:0];

		if (dec_i.cfg == rvv_pcpi_pkg::CFG_VILI)
			avl = rvv_cfg_pkg::word_t'(dec_i.imm);
		else if (dec_i.rs1_nonzero)
			avl = rs1_i;
		else if (dec_i.rd_nonzero)
			avl = '1;
		else
			avl = rvv_cfg_pkg::word_t'(vlmax);

		vl_new = (avl < rvv_cfg_pkg::word_t'(vlmax)) ? rvv_cfg_pkg::vl_t'(avl) : vlmax;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_o <= '{vill: 1'b1, default: '0};
			vl_o    <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= start_i;
			if (start_i) begin
				if (legal) begin
					vtype_o <= vt_new;
					vl_o    <= vl_new;
				end else begin
					vtype_o <= '{vill: 1'b1, default: '0};
					vl_o    <= '0;
				end
			end
		end
	end

endmodule

/* rtl/rvv_vregs.sv */
`timescale 1ns/100ps

module rvv_vregs (
	input  logic                  clk,
	input  rvv_pcpi_pkg::vrf_wr_t wr_i,
	input  rvv_pcpi_pkg::vrf_rd_t rd1_i,
	input  rvv_pcpi_pkg::vrf_rd_t rd2_i,
	output rvv_cfg_pkg::vreg_t    rdata1_o,
	output rvv_cfg_pkg::vreg_t    rdata2_o
);
	rvv_cfg_pkg::vreg_t regs [rvv_cfg_pkg::NUM_VREGS];

	initial begin
		for (int i = 0; i < rvv_cfg_pkg::NUM_VREGS; i++)
			regs[i] = '0;
	end

	always @(posedge clk) begin
		if (wr_i.en)
			regs[wr_i.addr] <= wr_i.data;
	end

	// both read ports are asynchronous
	assign rdata1_o = regs[rd1_i.addr];
	assign rdata2_o = regs[rd2_i.addr];

endmodule

/* rtl/rvv_lsu.sv */
`timescale 1ns/100ps

module rvv_lsu (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   start_i,
	input  rvv_pcpi_pkg::dec_t     dec_i,
	input  rvv_cfg_pkg::vtype_t    vtype_i,
	input  rvv_cfg_pkg::vl_t       vl_i,
	input  rvv_cfg_pkg::word_t     base_i,
	output rvv_pcpi_pkg::vrf_rd_t  vrf_rd_o,
	input  rvv_cfg_pkg::vreg_t     vrf_rdata_i,
	output rvv_pcpi_pkg::vrf_wr_t  vrf_wr_o,
	output rvv_pcpi_pkg::mem_req_t mem_req_o,
	input  logic                   mem_done_i,
	input  rvv_cfg_pkg::word_t     mem_rdata_i,
	output logic                   done_o
);
	typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_e;

	state_e              state;
	rvv_cfg_pkg::vl_t    idx;     // element index over the whole group

	// operation latched at start
	rvv_cfg_pkg::word_t  base_q;
	rvv_cfg_pkg::vaddr_t vd_q;
	rvv_cfg_pkg::sew_e   eew_q;
	logic                store_q;

	rvv_cfg_pkg::word_t  byte_pos;
	rvv_cfg_pkg::word_t  addr;
	rvv_cfg_pkg::vaddr_t reg_addr;
	rvv_cfg_pkg::word_t  wmask;   // element bits in a word
	rvv_cfg_pkg::word_t  elem;
	rvv_cfg_pkg::vreg_t  emask;
	rvv_cfg_pkg::vreg_t  ldata;
	logic [3:0]          bmask;
	logic [4:0]          lsh;     // bit position of the byte lane
	logic [$clog2(rvv_cfg_pkg::VLEN)-1:0] boff; // bit offset inside the register

	always_comb begin
		byte_pos = rvv_cfg_pkg::word_t'(idx) << eew_q;
		addr     = base_q + byte_pos;
		reg_addr = vd_q + rvv_cfg_pkg::vaddr_t'(byte_pos >> $clog2(rvv_cfg_pkg::VLENB));
		boff     = {byte_pos[$clog2(rvv_cfg_pkg::VLENB)-1:0], 3'b000};
		lsh      = {addr[1:0], 3'b000};

		case (eew_q)
			rvv_cfg_pkg::E8: begin
				wmask = 32'h0000_00ff;
				bmask = 4'b0001;
			end
			rvv_cfg_pkg::E16: begin
				wmask = 32'h0000_ffff;
				bmask = 4'b0011;
			end
			default: begin
				wmask = 32'hffff_ffff;
				bmask = 4'b1111;
			end
		endcase

		elem  = rvv_cfg_pkg::word_t'(vrf_rdata_i >> boff) & wmask;
		emask = rvv_cfg_pkg::vreg_t'(wmask) << boff;
		ldata = rvv_cfg_pkg::vreg_t'((mem_rdata_i >> lsh) & wmask) << boff;
	end

	assign vrf_rd_o.addr = reg_addr;

	// request is held for the single ISSUE cycle
	assign mem_req_o.valid = (state == ISSUE);
	assign mem_req_o.store = store_q;
	assign mem_req_o.addr  = addr;
	assign mem_req_o.wdata = elem << lsh;
	assign mem_req_o.strb  = bmask << addr[1:0];

	// load merges the returned lane into the current register
	assign vrf_wr_o.en   = (state == WAIT) && mem_done_i && !store_q;
	assign vrf_wr_o.addr = reg_addr;
	assign vrf_wr_o.data = (vrf_rdata_i & ~emask) | ldata;

	always_ff @(posedge clk) begin
		if (state == IDLE && start_i) begin
			base_q  <= base_i;
			vd_q    <= dec_i.vd;
			eew_q   <= dec_i.mem_sew;
			store_q <= (dec_i.cls == rvv_pcpi_pkg::CLS_STORE);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state  <= IDLE;
			idx    <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				IDLE: begin
					if (start_i) begin
						idx <= '0;
						if (vl_i == '0 || vtype_i.vill)
							done_o <= 1'b1; // nothing to transfer
						else
							state <= ISSUE;
					end
				end
				ISSUE: state <= WAIT;
				WAIT: begin
					if (mem_done_i) begin
						if (idx == vl_i - 1'b1) begin
							state  <= IDLE;
							done_o <= 1'b1;
						end else begin
							idx   <= idx + 1'b1;
							state <= ISSUE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/rvv_move_unit.sv */
`timescale 1ns/100ps

module rvv_move_unit (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  start_i,
	input  rvv_pcpi_pkg::dec_t    dec_i,
	input  rvv_cfg_pkg::vtype_t   vtype_i,
	input  rvv_cfg_pkg::vl_t      vl_i,
	input  rvv_cfg_pkg::word_t    rs1_i,
	output rvv_pcpi_pkg::vrf_rd_t vrf_rd1_o,
	output rvv_pcpi_pkg::vrf_rd_t vrf_rd2_o,
	input  rvv_cfg_pkg::vreg_t    vrf_rdata1_i,
	input  rvv_cfg_pkg::vreg_t    vrf_rdata2_i,
	output rvv_pcpi_pkg::vrf_wr_t vrf_wr_o,
	output rvv_cfg_pkg::word_t    scalar_o,
	output logic                  done_o
);
	typedef enum logic {IDLE, RUN} state_e;

	state_e              state;
	rvv_cfg_pkg::vaddr_t k;         // register within the group
	rvv_cfg_pkg::vl_t    remaining; // body elements not yet written
	rvv_cfg_pkg::vl_t    epr;       // elements per register
	rvv_cfg_pkg::word_t  scal;
	rvv_cfg_pkg::vreg_t  wdata;
	logic [1:0]          sew;

	assign sew  = vtype_i.sew[1:0];
	assign epr  = rvv_cfg_pkg::vl_t'(rvv_cfg_pkg::VLENB >> sew);
	assign scal = (dec_i.src == rvv_pcpi_pkg::SRC_IMM) ?
		{{27{dec_i.imm[4]}}, dec_i.imm} : rs1_i;

	always_comb begin
		int unsigned lane;
		wdata = vrf_rdata2_i; // tail keeps old vd
		for (int b = 0; b < rvv_cfg_pkg::VLENB; b++) begin
			lane = b & ((1 << sew) - 1);
			if ((b >> sew) < remaining) begin
				if (dec_i.src == rvv_pcpi_pkg::SRC_VEC)
					wdata[8*b +: 8] = vrf_rdata1_i[8*b +: 8];
				else
					wdata[8*b +: 8] = scal[8*lane +: 8]; // splat truncated to sew
			end
		end
	end

	assign vrf_rd1_o.addr = dec_i.vs1 + k;
	assign vrf_rd2_o.addr = (state == RUN) ? dec_i.vd + k : dec_i.vs2;

	assign vrf_wr_o.en   = (state == RUN);
	assign vrf_wr_o.addr = dec_i.vd + k;
	assign vrf_wr_o.data = wdata;

	// element 0 of vs2, sign extended
	always_ff @(posedge clk) begin
		if (state == IDLE && start_i) begin
			case (sew)
				2'd0:    scalar_o <= {{24{vrf_rdata2_i[7]}}, vrf_rdata2_i[7:0]};
				2'd1:    scalar_o <= {{16{vrf_rdata2_i[15]}}, vrf_rdata2_i[15:0]};
				default: scalar_o <= vrf_rdata2_i[31:0];
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= IDLE;
			k         <= '0;
			remaining <= '0;
			done_o    <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				IDLE: begin
					if (start_i) begin
						if (dec_i.cls == rvv_pcpi_pkg::CLS_MVXS) begin
							done_o <= 1'b1;
						end else begin
							state     <= RUN;
							k         <= '0;
							remaining <= vl_i;
						end
					end
				end
				RUN: begin
					k <= k + 1'b1;
					if (remaining <= epr) begin // last register, always at least one
						remaining <= '0;
						state     <= IDLE;
						done_o    <= 1'b1;
					end else begin
						remaining <= remaining - epr;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/rvv_coproc.sv */
`timescale 1ns/100ps

module rvv_coproc (
	input  logic                    clk,
	input  logic                    resetn,
	input  rvv_pcpi_pkg::pcpi_req_t pcpi_req_i,
	output rvv_pcpi_pkg::pcpi_rsp_t pcpi_rsp_o,
	output logic                    pcpi_is_rvv_o,
	output rvv_pcpi_pkg::mem_req_t  mem_req_o,
	input  logic                    mem_done_i,
	input  rvv_cfg_pkg::word_t      mem_rdata_i
);
	typedef enum logic [1:0] {U_NONE, U_CSR, U_LSU, U_MOVE} unit_e;

	unit_e                 active, next_unit;
	logic                  start_q;
	logic                  dispatch;
	logic                  csr_done, lsu_done, mv_done;
	rvv_pcpi_pkg::dec_t    dec;
	rvv_cfg_pkg::vtype_t   vtype;
	rvv_cfg_pkg::vl_t      vl;
	rvv_cfg_pkg::word_t    mv_scalar;
	rvv_cfg_pkg::vreg_t    rdata1, rdata2;
	rvv_pcpi_pkg::vrf_wr_t lsu_wr, mv_wr, vrf_wr;
	rvv_pcpi_pkg::vrf_rd_t lsu_rd, mv_rd1, mv_rd2, vrf_rd1;

	rvv_decoder i_dec (.insn_i(pcpi_req_i.insn), .dec_o(dec));

	assign pcpi_is_rvv_o = (dec.cls != rvv_pcpi_pkg::CLS_NONE);
	assign dispatch = pcpi_req_i.valid && !pcpi_rsp_o.ready && active == U_NONE && pcpi_is_rvv_o;

	always_comb begin
		case (dec.cls)
			rvv_pcpi_pkg::CLS_CFG:                         next_unit = U_CSR;
			rvv_pcpi_pkg::CLS_LOAD, rvv_pcpi_pkg::CLS_STORE: next_unit = U_LSU;
			rvv_pcpi_pkg::CLS_MOVE, rvv_pcpi_pkg::CLS_MVXS:  next_unit = U_MOVE;
			default:                                       next_unit = U_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active     <= U_NONE;
			start_q    <= 1'b0;
			pcpi_rsp_o <= '0;
		end else begin
			start_q          <= dispatch;
			pcpi_rsp_o.ready <= 1'b0;
			pcpi_rsp_o.wr    <= 1'b0;
			if (dispatch) begin
				active             <= next_unit;
				pcpi_rsp_o.waiting <= 1'b1;
			end else if (csr_done || lsu_done || mv_done) begin
				active             <= U_NONE;
				pcpi_rsp_o.ready   <= 1'b1;
				pcpi_rsp_o.waiting <= 1'b0;
				pcpi_rsp_o.wr      <= csr_done || (mv_done && dec.cls == rvv_pcpi_pkg::CLS_MVXS);
				pcpi_rsp_o.rd      <= csr_done ? rvv_cfg_pkg::word_t'(vl) : mv_scalar;
			end
		end
	end

	// register file belongs to whichever unit is active
	assign vrf_wr  = (active == U_LSU) ? lsu_wr : mv_wr;
	assign vrf_rd1 = (active == U_LSU) ? lsu_rd : mv_rd1;

	rvv_csr i_csr (
		.clk(clk), .resetn(resetn), .start_i(start_q && active == U_CSR), .dec_i(dec),
		.rs1_i(pcpi_req_i.rs1), .rs2_i(pcpi_req_i.rs2), .vtype_o(vtype), .vl_o(vl),
		.done_o(csr_done)
	);

	rvv_vregs i_vregs (
		.clk(clk), .wr_i(vrf_wr), .rd1_i(vrf_rd1), .rd2_i(mv_rd2),
		.rdata1_o(rdata1), .rdata2_o(rdata2)
	);

	rvv_lsu i_lsu (
		.clk(clk), .resetn(resetn), .start_i(start_q && active == U_LSU), .dec_i(dec),
		.vtype_i(vtype), .vl_i(vl), .base_i(pcpi_req_i.rs1), .vrf_rd_o(lsu_rd),
		.vrf_rdata_i(rdata1), .vrf_wr_o(lsu_wr), .mem_req_o(mem_req_o),
		.mem_done_i(mem_done_i), .mem_rdata_i(mem_rdata_i), .done_o(lsu_done)
	);

	rvv_move_unit i_move (
		.clk(clk), .resetn(resetn), .start_i(start_q && active == U_MOVE), .dec_i(dec),
		.vtype_i(vtype), .vl_i(vl), .rs1_i(pcpi_req_i.rs1), .vrf_rd1_o(mv_rd1),
		.vrf_rd2_o(mv_rd2), .vrf_rdata1_i(rdata1), .vrf_rdata2_i(rdata2),
		.vrf_wr_o(mv_wr), .scalar_o(mv_scalar), .done_o(mv_done)
	);

endmodule

/* bench/tb_rvv_coproc.sv */
`timescale 1ns/100ps

module tb_rvv_coproc;

	localparam logic [1:0] CHK_VAR   = 2'd0; // memory op with free latency
	localparam logic [1:0] CHK_LAT   = 2'd1; // fixed latency
	localparam logic [1:0] CHK_NOREQ = 2'd2; // fixed latency and no memory traffic

	localparam logic [2:0] WIDTH_8  = 3'b000;
	localparam logic [2:0] WIDTH_16 = 3'b101;
	localparam logic [2:0] WIDTH_32 = 3'b110;

	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic        wr;
		logic [31:0] rd;
		logic [1:0]  tag;
		logic [3:0]  lat;   // edges from first valid edge to ready
	} entry_t;

	logic                    clk;
	logic                    resetn;
	rvv_pcpi_pkg::pcpi_req_t pcpi_req;
	rvv_pcpi_pkg::pcpi_rsp_t pcpi_rsp;
	logic                    is_rvv;
	rvv_pcpi_pkg::mem_req_t  mem_req;
	logic                    mem_done;
	logic [31:0]             mem_rdata;

	logic [31:0] mem [256];
	logic [31:0] exp_mem [256];
	entry_t      tests [$];
	logic [31:0] rng = 32'd83429;
	int          req_count = 0;
	int          err_count = 0;
	int          check_count = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	rvv_coproc i_dut (
		.clk(clk), .resetn(resetn), .pcpi_req_i(pcpi_req), .pcpi_rsp_o(pcpi_rsp),
		.pcpi_is_rvv_o(is_rvv), .mem_req_o(mem_req), .mem_done_i(mem_done),
		.mem_rdata_i(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every byte depends on the full word index
	function automatic logic [31:0] fill_word(input int i);
		logic [7:0] ix;
		ix = i[7:0];
		return {ix ^ 8'h3c, ix + 8'h91, ~ix, {ix[3:0], ix[7:4]} ^ 8'hc5};
	endfunction

	function automatic logic [7:0] vtype_bits(input int sew, input int lmul);
		return {2'b00, sew[2:0], lmul[2:0]}; // vma, vta, vsew, vlmul
	endfunction

	function automatic logic [31:0] vsetvli_word(input int rd, input int rs1, input logic [7:0] vt);
		return {4'b0000, vt, rs1[4:0], 3'b111, rd[4:0], 7'b1010111};
	endfunction

	function automatic logic [31:0] vsetivli_word(input int rd, input int uimm,
			input logic [7:0] vt);
		return {4'b1100, vt, uimm[4:0], 3'b111, rd[4:0], 7'b1010111};
	endfunction

	function automatic logic [31:0] vsetvl_word(input int rd, input int rs1, input int rs2);
		return {7'b1000000, rs2[4:0], rs1[4:0], 3'b111, rd[4:0], 7'b1010111};
	endfunction

	// unmasked unit stride
	function automatic logic [31:0] vmem_word(input logic store, input logic [2:0] width,
			input int vreg, input int rs1);
		return {6'd0, 1'b1, 5'd0, rs1[4:0], width, vreg[4:0],
			store ? 7'b0100111 : 7'b0000111};
	endfunction

	function automatic logic [31:0] vmv_word(input logic [2:0] f3, input int vd, input int src);
		return {6'b010111, 1'b1, 5'd0, src[4:0], f3, vd[4:0], 7'b1010111};
	endfunction

	function automatic logic [31:0] vmvxs_word(input int rd, input int vs2);
		return {6'b010000, 1'b1, vs2[4:0], 5'd0, 3'b010, rd[4:0], 7'b1010111};
	endfunction

	// ceil(vl * sew / VLEN) register writes but at least one
	function automatic int move_edges(input int vl, input int sew_bits);
		int n;
		n = (vl * sew_bits + 127) / 128;
		return 2 + ((n < 1) ? 1 : n);
	endfunction

	task automatic add_entry(input logic [31:0] insn, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic wr, input logic [31:0] rd,
			input logic [1:0] tag, input int lat);
		entry_t e;
		e.insn = insn;
		e.rs1  = rs1;
		e.rs2  = rs2;
		e.wr   = wr;
		e.rd   = rd;
		e.tag  = tag;
		e.lat  = lat[3:0];
		tests.push_back(e);
	endtask

	task automatic set_vl(input int sew, input int lmul, input int avl);
		int vlmax;
		vlmax = (128 / (8 << sew)) << lmul;
		add_entry(vsetvli_word(5, 6, vtype_bits(sew, lmul)), avl, 0, 1'b1,
			(avl < vlmax) ? avl : vlmax, CHK_LAT, 2);
	endtask

	task automatic mem_entry(input logic store, input logic [2:0] width, input int vreg,
			input int base);
		add_entry(vmem_word(store, width, vreg, 10), base, 0, 1'b0, 0, CHK_VAR, 0);
	endtask

	task automatic copy_expect(input int src, input int dst, input int n);
		for (int j = 0; j < n; j++)
			exp_mem[(dst + j) >> 2][8 * ((dst + j) % 4) +: 8] =
				exp_mem[(src + j) >> 2][8 * ((src + j) % 4) +: 8];
	endtask

	task automatic splat_expect(input int dst, input int n, input logic [7:0] v);
		for (int j = 0; j < n; j++)
			exp_mem[(dst + j) >> 2][8 * ((dst + j) % 4) +: 8] = v;
	endtask

	task automatic build_tests();
		int vlmax;
		// vill after reset so nothing moves
		add_entry(vmem_word(1'b0, WIDTH_8, 1, 10), 0, 0, 1'b0, 0, CHK_NOREQ, 2);
		for (int s = 0; s < 3; s++) begin
			for (int l = 0; l < 4; l++) begin
				vlmax = (128 / (8 << s)) << l;
				set_vl(s, l, 20);
				add_entry(vsetvli_word(5, 0, vtype_bits(s, l)), 0, 0, 1'b1, vlmax, CHK_LAT, 2);
				add_entry(vsetivli_word(5, 3, vtype_bits(s, l)), 0, 0, 1'b1, 3, CHK_LAT, 2);
			end
		end
		add_entry(vsetvl_word(5, 6, 7), 100, vtype_bits(1, 2), 1'b1, 32, CHK_LAT, 2);
		add_entry(vsetvli_word(5, 6, vtype_bits(0, 7)), 20, 0, 1'b1, 0, CHK_LAT, 2); // mf2
		add_entry(vsetvli_word(5, 6, vtype_bits(2, 5)), 20, 0, 1'b1, 0, CHK_LAT, 2); // mf8
		add_entry(vsetivli_word(5, 3, vtype_bits(1, 6)), 0, 0, 1'b1, 0, CHK_LAT, 2);
		add_entry(vsetvli_word(5, 6, vtype_bits(3, 0)), 20, 0, 1'b1, 0, CHK_LAT, 2); // e64

		// one round trip per width
		set_vl(0, 0, 13);
		mem_entry(1'b0, WIDTH_8, 1, 'h000);
		mem_entry(1'b1, WIDTH_8, 1, 'h040);
		copy_expect('h000, 'h040, 13);
		set_vl(1, 1, 11);
		mem_entry(1'b0, WIDTH_16, 2, 'h080);
		mem_entry(1'b1, WIDTH_16, 2, 'h0c0);
		copy_expect('h080, 'h0c0, 22);
		set_vl(2, 2, 13);
		mem_entry(1'b0, WIDTH_32, 4, 'h100);
		mem_entry(1'b1, WIDTH_32, 4, 'h180);
		copy_expect('h100, 'h180, 52);

		// vmv.v.i over a loaded pattern keeps the tail
		set_vl(0, 0, 16);
		mem_entry(1'b0, WIDTH_8, 8, 'h200);
		set_vl(0, 0, 5);
		add_entry(vmv_word(3'b011, 8, 5'b11101), 0, 0, 1'b0, 0, CHK_LAT, move_edges(5, 8));
		set_vl(0, 0, 16);
		mem_entry(1'b1, WIDTH_8, 8, 'h240);
		copy_expect('h200, 'h240, 16);
		splat_expect('h240, 5, 8'hfd);
		// vmv.v.x with rs1 truncated to one byte
		mem_entry(1'b0, WIDTH_8, 9, 'h200);
		set_vl(0, 0, 5);
		add_entry(vmv_word(3'b100, 9, 11), 32'h1234_5678, 0, 1'b0, 0, CHK_LAT,
			move_edges(5, 8));
		set_vl(0, 0, 16);
		mem_entry(1'b1, WIDTH_8, 9, 'h280);
		copy_expect('h200, 'h280, 16);
		splat_expect('h280, 5, 8'h78);
		add_entry(vmvxs_word(5, 8), 0, 0, 1'b1, 32'hffff_fffd, CHK_LAT, 2); // 0xfd extended

		// vmv.v.v over an m2 group at e32
		set_vl(2, 1, 8);
		mem_entry(1'b0, WIDTH_32, 10, 'h300);
		add_entry(vmv_word(3'b000, 12, 10), 0, 0, 1'b0, 0, CHK_LAT, move_edges(8, 32));
		mem_entry(1'b1, WIDTH_32, 12, 'h340);
		copy_expect('h300, 'h340, 32);
		add_entry(vmvxs_word(5, 12), 0, 0, 1'b1, fill_word('h300 >> 2), CHK_LAT, 2);

		// vl = 0 with a legal vtype
		set_vl(2, 0, 0);
		add_entry(vmem_word(1'b1, WIDTH_32, 4, 10), 'h3c0, 0, 1'b0, 0, CHK_NOREQ, 2);

		// vl = 0 after an illegal vtype
		add_entry(vsetvli_word(5, 6, vtype_bits(3, 0)), 20, 0, 1'b1, 0, CHK_LAT, 2);
		add_entry(vmem_word(1'b0, WIDTH_32, 4, 10), 'h000, 0, 1'b0, 0, CHK_NOREQ, 2);
		add_entry(vmem_word(1'b1, WIDTH_8, 1, 10), 'h380, 0, 1'b0, 0, CHK_NOREQ, 2);
	endtask

	// behaves like the core and holds valid until ready
	task automatic run_entry(input entry_t e, input int n);
		int edges;
		int reqs_before;
		edges = 0;
		reqs_before = req_count;
		pcpi_req.valid = 1'b1;
		pcpi_req.insn  = e.insn;
		pcpi_req.rs1   = e.rs1;
		pcpi_req.rs2   = e.rs2;
		do begin
			@(posedge clk);
			#2;
			edges++;
			if (!pcpi_rsp.ready && !pcpi_rsp.waiting) begin
				$display("entry %0d dropped wait before ready at %0t", n, $time);
				err_count++;
			end
		end while (!pcpi_rsp.ready);
		check_count++;
		if (is_rvv !== 1'b1) begin
			$display("ERR %0t: entry %0d not claimed as vector instruction", $time, n);
			err_count++;
		end
		if (pcpi_rsp.wr !== e.wr) begin
			$display("ERR %0t: entry %0d wr is %b, expected %b", $time, n, pcpi_rsp.wr, e.wr);
			err_count++;
		end
		if (e.wr && pcpi_rsp.rd !== e.rd) begin
			$display("ERR %0t: entry %0d rd is %h, expected %h", $time, n, pcpi_rsp.rd, e.rd);
			err_count++;
		end
		if (e.tag != CHK_VAR && edges - 1 != e.lat) begin
			$display("ERR %0t: entry %0d ready after %0d edges, expected %0d", $time, n,
				edges - 1, e.lat);
			err_count++;
		end
		if (e.tag == CHK_NOREQ && req_count != reqs_before) begin
			$display("entry %0d issued memory requests although vl is zero", n);
			err_count++;
		end
		pcpi_req = '0;
		@(posedge clk);
		#2;
		if (pcpi_rsp.ready !== 1'b0 || pcpi_rsp.waiting !== 1'b0) begin
			$display("ERR %0t: entry %0d response still active a cycle after ready", $time, n);
			err_count++;
		end
	endtask

	// memory model with one outstanding request and 0 to 3 cycles of extra delay
	initial begin
		logic       pending;
		int         delay;
		logic [7:0] widx;
		mem_done  = 1'b0;
		mem_rdata = '0;
		pending   = 1'b0;
		delay     = 0;
		widx      = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i);
		forever begin
			@(posedge clk);
			#2;
			mem_done = 1'b0;
			if (pending && mem_req.valid) begin
				$display("memory request at %0t while another one was outstanding", $time);
				err_count++;
			end
			if (pending) begin
				if (delay == 0) begin
					mem_rdata = mem[widx];
					mem_done  = 1'b1;
					pending   = 1'b0;
				end else begin
					delay--;
				end
			end else if (mem_req.valid) begin
				req_count++;
				if (mem_req.addr[31:10] != '0) begin
					$display("memory request at %0t outside the modelled memory", $time);
					err_count++;
				end
				widx    = mem_req.addr[9:2];
				rng     = xorshift32(rng);
				delay   = int'(rng[1:0]);
				pending = 1'b1;
				if (mem_req.store) begin
					for (int b = 0; b < 4; b++)
						if (mem_req.strb[b])
							mem[widx][8*b +: 8] = mem_req.wdata[8*b +: 8];
				end
			end
		end
	end

	initial begin
		pcpi_req = '0;
		resetn   = 1'b0;
		for (int i = 0; i < 256; i++)
			exp_mem[i] = fill_word(i);
		build_tests();
		cycle_limit = tests.size() * 32 * 6 + 200;

		// decoder rejects foreign and masked words
		pcpi_req.insn = 32'h00b5_0533; // add a0, a0, a1
		#1;
		check_count++;
		if (is_rvv !== 1'b0) begin
			$display("ERR %0t: scalar add claimed as vector instruction", $time);
			err_count++;
		end
		pcpi_req.insn = vmem_word(1'b0, WIDTH_8, 1, 10) & ~32'h0200_0000;
		#1;
		check_count++;
		if (is_rvv !== 1'b0) begin
			$display("ERR %0t: masked load claimed as vector instruction", $time);
			err_count++;
		end
		pcpi_req.insn = '0;

		repeat (3) @(posedge clk);
		#2;
		resetn = 1'b1;
		check_count++;
		if (pcpi_rsp.ready || pcpi_rsp.wr || pcpi_rsp.waiting || mem_req.valid) begin
			$display("ERR %0t: outputs not idle after reset", $time);
			err_count++;
		end

		for (int i = 0; i < tests.size(); i++)
			run_entry(tests[i], i);

		for (int i = 0; i < 256; i++) begin
			check_count++;
			if (mem[i] !== exp_mem[i]) begin
				$display("ERR %0t: memory word at %h is %h, expected %h", $time, i * 4,
					mem[i], exp_mem[i]);
				err_count++;
			end
		end

		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* src.f */
rtl/rvv_cfg_pkg.sv
rtl/rvv_pcpi_pkg.sv
rtl/rvv_decoder.sv
rtl/rvv_csr.sv
rtl/rvv_vregs.sv
rtl/rvv_lsu.sv
rtl/rvv_move_unit.sv
rtl/rvv_coproc.sv
bench/tb_rvv_coproc.sv
